// ==== Bender.yml ====
package:
  name: front_panel

sources:
  # RTL
  - include_dirs:
      - include
    files:
      - source/ui_pkg.sv
      - source/button_debouncer.sv
      - source/menu_controller.sv
      - source/front_panel_top.sv

  # Testbench
  - target: test
    include_dirs:
      - include
    files:
      - test/front_panel_tb.sv

// ==== include/ui_consts.svh ====
`ifndef UI_CONSTS_SVH
`define UI_CONSTS_SVH

////////////////////
// Button bus layout
////////////////////

// Bit positions on the raw button bus
`define BTN_PREV    0
`define BTN_NEXT    1
`define BTN_OKAY    2
`define BTN_CANCEL  3

// Width of the button bus
`define BTN_COUNT   4

////////////////////
// Menu and timing
////////////////////

// Highest cursor position, the restore item
`define MENU_LAST_INDEX 10

// Clocks a synchronized level must hold before it is accepted
`define DEBOUNCE_CYCLES 16

// Flops in each input synchronizer
`define SYNC_STAGES 2

`endif

// ==== sim.f ====
+incdir+include
source/ui_pkg.sv
source/button_debouncer.sv
source/menu_controller.sv
source/front_panel_top.sv
test/front_panel_tb.sv

// ==== source/button_debouncer.sv ====
`timescale 1ns/1ps

`include "ui_consts.svh"

// Turns raw push button levels into one-cycle press pulses
module button_debouncer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    // Raw asynchronous levels, active high
    input  logic [`BTN_COUNT-1:0] button,
    // One pulse per accepted press
    output logic [`BTN_COUNT-1:0] press
);

    // Counter wide enough for DEBOUNCE_CYCLES - 1
    localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES);

    ////////////////////
    // Per-button path
    ////////////////////

    for (genvar b = 0; b < `BTN_COUNT; b++) begin : g_btn

        // Synchronizer chain, newest sample at bit 0
        logic [`SYNC_STAGES-1:0] sync_q;
        // Clocks the synced level has differed from the accepted one
        logic [CNT_W-1:0]        stable_cnt;
        // Accepted level and its one-cycle delayed copy
        logic                    level_q;
        logic                    level_d;
        logic                    pulse_q;
        logic                    level_sync;

        // Oldest synchronizer stage is the safe level
        assign level_sync = sync_q[`SYNC_STAGES-1];
        assign press[b]   = pulse_q;

        // Synchronizer runs regardless of en
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                sync_q <= '0;
            end else begin
                sync_q <= {sync_q[`SYNC_STAGES-2:0], button[b]};
            end
        end

        // Stability counter and accepted level
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                stable_cnt <= '0;
                level_q    <= 1'b0;
                level_d    <= 1'b0;
                pulse_q    <= 1'b0;
            end else if (!en) begin
                // Disabled, hold everything cleared
                stable_cnt <= '0;
                level_q    <= 1'b0;
                level_d    <= 1'b0;
                pulse_q    <= 1'b0;
            end else begin
                level_d <= level_q;
                // Rising accepted level gives one registered pulse
                pulse_q <= level_q & ~level_d;

                if (level_sync == level_q) begin
                    // Level agrees, any pending change is dropped
                    stable_cnt <= '0;
                end else if (stable_cnt == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
                    // Held long enough
                    level_q    <= level_sync;
                    stable_cnt <= '0;
                end else begin
                    stable_cnt <= stable_cnt + 1'b1;
                end
            end
        end

        ////////////////////
        // Checks
        ////////////////////

        // A press lasts exactly one cycle
        a_press_single: assert property (
            @(posedge clk) disable iff (!rst_n)
            pulse_q |=> !pulse_q
        ) else $error("press[%0d] high on two consecutive cycles", b);

    end

endmodule

// ==== source/front_panel_top.sv ====
`timescale 1ns/1ps

`include "ui_consts.svh"

// Front panel input path, raw buttons in and menu state out
module front_panel_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // Global enable, synchronous level
    input  logic                   en,
    // Raw push buttons, previous next okay cancel
    input  logic [`BTN_COUNT-1:0]  button,
    // Current menu item under the cursor
    output ui_pkg::menu_item_e     cursor_index,
    // Sine periods for the LCD drawer
    output ui_pkg::period_count_e  period_count,
    // Divider select for the pulse counter
    output ui_pkg::gain_div_e      gain_div
);

    ////////////////////
    // Internal wiring
    ////////////////////

    // Menu state straight from the controller
    ui_pkg::menu_item_e    menu_cursor;
    ui_pkg::period_count_e menu_periods;
    ui_pkg::gain_div_e     menu_gain;

    ////////////////////
    // Menu controller
    ////////////////////

    // Debouncer lives inside the controller
    menu_controller u_menu (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .button       (button),
        .cursor_index (menu_cursor),
        .period_count (menu_periods),
        .gain_div     (menu_gain)
    );

    // Outputs to the display consumers
    assign cursor_index = menu_cursor;
    assign period_count = menu_periods;
    assign gain_div     = menu_gain;

endmodule

// ==== source/menu_controller.sv ====
`timescale 1ns/1ps

`include "ui_consts.svh"

// Menu cursor and setting registers, driven by debounced presses
module menu_controller (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    // Raw levels, previous next okay cancel
    input  logic [`BTN_COUNT-1:0]  button,
    output ui_pkg::menu_item_e     cursor_index,
    // Sine periods drawn on the LCD, minus one
    output ui_pkg::period_count_e  period_count,
    // Pulse counter gain divider
    output ui_pkg::gain_div_e      gain_div
);

    ////////////////////
    // Button conditioning
    ////////////////////

    // One-cycle pulses, one per button
    logic [`BTN_COUNT-1:0] press;

    button_debouncer u_debouncer (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (en),
        .button (button),
        .press  (press)
    );

    ////////////////////
    // Cursor stepping
    ////////////////////

    ui_pkg::menu_item_e cursor_prev;
    ui_pkg::menu_item_e cursor_next;

    // Previous wraps from the first item to the last
    always_comb begin
        if (cursor_index == ui_pkg::ITEM_PERIOD1) begin
            cursor_prev = ui_pkg::menu_item_e'(4'(`MENU_LAST_INDEX));
        end else begin
            cursor_prev = ui_pkg::menu_item_e'(cursor_index - 4'd1);
        end
    end

    // Next wraps from the last item to the first
    always_comb begin
        if (cursor_index >= 4'(`MENU_LAST_INDEX)) begin
            cursor_next = ui_pkg::ITEM_PERIOD1;
        end else begin
            cursor_next = ui_pkg::menu_item_e'(cursor_index + 4'd1);
        end
    end

    ////////////////////
    // Okay decode
    ////////////////////

    ui_pkg::period_count_e period_sel;
    ui_pkg::gain_div_e     gain_sel;

    // Setting chosen by okay on the current item
    always_comb begin
        // Items of the other group leave a setting alone
        period_sel = period_count;
        gain_sel   = gain_div;
        case (cursor_index)
            // Period group
            ui_pkg::ITEM_PERIOD1: period_sel = ui_pkg::PERIODS_1;
            ui_pkg::ITEM_PERIOD2: period_sel = ui_pkg::PERIODS_2;
            ui_pkg::ITEM_PERIOD3: period_sel = ui_pkg::PERIODS_3;
            ui_pkg::ITEM_PERIOD4: period_sel = ui_pkg::PERIODS_4;
            ui_pkg::ITEM_PERIOD5: period_sel = ui_pkg::PERIODS_5;
            // Divider group
            ui_pkg::ITEM_DIV_OFF: gain_sel = ui_pkg::DIV_OFF;
            ui_pkg::ITEM_DIV_1:   gain_sel = ui_pkg::DIV_1;
            ui_pkg::ITEM_DIV_2:   gain_sel = ui_pkg::DIV_2;
            ui_pkg::ITEM_DIV_4:   gain_sel = ui_pkg::DIV_4;
            ui_pkg::ITEM_DIV_8:   gain_sel = ui_pkg::DIV_8;
            // Restore defaults
            ui_pkg::ITEM_RESTORE: begin
                period_sel = ui_pkg::PERIODS_1;
                gain_sel   = ui_pkg::DIV_OFF;
            end
            default: begin
                period_sel = period_count;
                gain_sel   = gain_div;
            end
        endcase
    end

    ////////////////////
    // Registers
    ////////////////////

    // Priority is previous, next, okay, cancel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cursor_index <= ui_pkg::ITEM_PERIOD1;
            period_count <= ui_pkg::PERIODS_1;
            gain_div     <= ui_pkg::DIV_OFF;
        end else if (!en) begin
            // Global enable low clears every output
            cursor_index <= ui_pkg::ITEM_PERIOD1;
            period_count <= ui_pkg::PERIODS_1;
            gain_div     <= ui_pkg::DIV_OFF;
        end else if (press[`BTN_PREV]) begin
            cursor_index <= cursor_prev;
        end else if (press[`BTN_NEXT]) begin
            cursor_index <= cursor_next;
        end else if (press[`BTN_OKAY]) begin
            period_count <= period_sel;
            gain_div     <= gain_sel;
        end else if (press[`BTN_CANCEL]) begin
            // Back to the top of the menu, settings kept
            cursor_index <= ui_pkg::ITEM_PERIOD1;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Cursor stays inside the menu
    a_cursor_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        cursor_index <= 4'(`MENU_LAST_INDEX)
    ) else $error("cursor_index %0d beyond last item", cursor_index);

    // Enable low clears all outputs on the next edge
    a_enable_clear: assert property (
        @(posedge clk) disable iff (!rst_n)
        !en |=> (cursor_index == ui_pkg::ITEM_PERIOD1 &&
                 period_count == ui_pkg::PERIODS_1 &&
                 gain_div == ui_pkg::DIV_OFF)
    ) else $error("outputs not cleared after en low");

endmodule

// ==== source/ui_pkg.sv ====
package ui_pkg;

    ////////////////////
    // Menu items
    ////////////////////

    // Cursor positions, in on-screen order
    typedef enum logic [3:0] {
        ITEM_PERIOD1 = 4'd0,
        ITEM_PERIOD2 = 4'd1,
        ITEM_PERIOD3 = 4'd2,
        ITEM_PERIOD4 = 4'd3,
        ITEM_PERIOD5 = 4'd4,
        // Gain divider group
        ITEM_DIV_OFF = 4'd5,
        ITEM_DIV_1   = 4'd6,
        ITEM_DIV_2   = 4'd7,
        ITEM_DIV_4   = 4'd8,
        ITEM_DIV_8   = 4'd9,
        // Both settings back to defaults
        ITEM_RESTORE = 4'd10
    } menu_item_e;

    ////////////////////
    // Settings
    ////////////////////

    // Drawn sine periods minus one
    typedef enum logic [2:0] {
        PERIODS_1 = 3'd0,
        PERIODS_2 = 3'd1,
        PERIODS_3 = 3'd2,
        PERIODS_4 = 3'd3,
        PERIODS_5 = 3'd4
    } period_count_e;

    // Pulse counter gain divider select
    typedef enum logic [2:0] {
        DIV_OFF = 3'd0,
        DIV_1   = 3'd1,
        DIV_2   = 3'd2,
        DIV_4   = 3'd3,
        DIV_8   = 3'd4
    } gain_div_e;

endpackage

// ==== test/front_panel_tb.sv ====
`timescale 1ns/1ps

`include "ui_consts.svh"

// Table-driven testbench for the front panel input path
module front_panel_tb;

    ////////////////////
    // Constants
    ////////////////////

    localparam int CLK_PERIOD = 8;
    // Normal press and a long hold
    localparam int HOLD       = `DEBOUNCE_CYCLES + 4;
    localparam int LONG_HOLD  = `DEBOUNCE_CYCLES * 10;
    // Idle after release, covers the full press latency
    localparam int IDLE       = `DEBOUNCE_CYCLES + 6;
    localparam int NUM_GLITCH = 24;

    // Single-button masks
    localparam logic [3:0] M_PREV   = 4'(1 << `BTN_PREV);
    localparam logic [3:0] M_NEXT   = 4'(1 << `BTN_NEXT);
    localparam logic [3:0] M_OKAY   = 4'(1 << `BTN_OKAY);
    localparam logic [3:0] M_CANCEL = 4'(1 << `BTN_CANCEL);

    ////////////////////
    // DUT signals
    ////////////////////

    logic                  clk;
    logic                  rst_n;
    logic                  en;
    logic [`BTN_COUNT-1:0] button;
    ui_pkg::menu_item_e    cursor_index;
    ui_pkg::period_count_e period_count;
    ui_pkg::gain_div_e     gain_div;

    // Stimulus table, one entry per press
    logic [3:0] tbl_mask[$];
    int         tbl_hold[$];
    logic [3:0] tbl_cursor[$];
    logic [2:0] tbl_period[$];
    logic [2:0] tbl_gain[$];
    logic       table_ready;

    int errors;
    int checks;
    int seed;

    front_panel_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .button       (button),
        .cursor_index (cursor_index),
        .period_count (period_count),
        .gain_div     (gain_div)
    );

    // 8 ns clock
    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////

    // Append one press with its expected outputs
    task automatic add_entry(input logic [3:0] mask, input int hold,
                             input logic [3:0] c, input logic [2:0] p,
                             input logic [2:0] g);
        tbl_mask.push_back(mask);
        tbl_hold.push_back(hold);
        tbl_cursor.push_back(c);
        tbl_period.push_back(p);
        tbl_gain.push_back(g);
    endtask

    // Hold a button mask, release it, then let the path settle
    task automatic press_buttons(input logic [3:0] mask, input int hold);
        @(posedge clk);
        #1 button = mask;
        repeat (hold) @(posedge clk);
        #1 button = '0;
        repeat (IDLE) @(posedge clk);
        // Sample away from the edge
        #1;
    endtask

    // Compare all three outputs
    task automatic check_outputs(input logic [3:0] c, input logic [2:0] p,
                                 input logic [2:0] g, input string tag);
        checks++;
        if (cursor_index !== c) begin
            $display("[ERROR] %0t: %s cursor_index expected %0d, got %0d",
                     $time, tag, c, cursor_index);
            errors++;
        end
        if (period_count !== p) begin
            $display("[ERROR] %0t: %s period_count expected %0d, got %0d",
                     $time, tag, p, period_count);
            errors++;
        end
        if (gain_div !== g) begin
            $display("[ERROR] %0t: %s gain_div expected %0d, got %0d",
                     $time, tag, g, gain_div);
            errors++;
        end
    endtask

    ////////////////////
    // Expected sequence
    ////////////////////

    // Worked out by hand from the menu rules
    task automatic load_table();
        // Next from reset walks every item, then wraps
        for (int i = 1; i <= `MENU_LAST_INDEX; i++) begin
            add_entry(M_NEXT, HOLD, 4'(i), 3'd0, 3'd0);
        end
        add_entry(M_NEXT, HOLD, 4'd0, 3'd0, 3'd0);
        // Previous from the top wraps to restore item
        add_entry(M_PREV, HOLD, 4'd10, 3'd0, 3'd0);
        add_entry(M_CANCEL, HOLD, 4'd0, 3'd0, 3'd0);
        // Period selection on items 2 and 4
        add_entry(M_NEXT, HOLD, 4'd1, 3'd0, 3'd0);
        add_entry(M_NEXT, HOLD, 4'd2, 3'd0, 3'd0);
        add_entry(M_OKAY, HOLD, 4'd2, 3'd2, 3'd0);
        add_entry(M_NEXT, HOLD, 4'd3, 3'd2, 3'd0);
        add_entry(M_NEXT, HOLD, 4'd4, 3'd2, 3'd0);
        add_entry(M_OKAY, HOLD, 4'd4, 3'd4, 3'd0);
        // Divider selection on items 8, 5 and 9, period kept
        add_entry(M_NEXT, HOLD, 4'd5, 3'd4, 3'd0);
        add_entry(M_NEXT, HOLD, 4'd6, 3'd4, 3'd0);
        add_entry(M_NEXT, HOLD, 4'd7, 3'd4, 3'd0);
        add_entry(M_NEXT, HOLD, 4'd8, 3'd4, 3'd0);
        add_entry(M_OKAY, HOLD, 4'd8, 3'd4, 3'd3);
        // Back down so okay on item 5 has something to clear
        add_entry(M_PREV, HOLD, 4'd7, 3'd4, 3'd3);
        add_entry(M_PREV, HOLD, 4'd6, 3'd4, 3'd3);
        add_entry(M_PREV, HOLD, 4'd5, 3'd4, 3'd3);
        add_entry(M_OKAY, HOLD, 4'd5, 3'd4, 3'd0);
        add_entry(M_NEXT, HOLD, 4'd6, 3'd4, 3'd0);
        add_entry(M_NEXT, HOLD, 4'd7, 3'd4, 3'd0);
        add_entry(M_NEXT, HOLD, 4'd8, 3'd4, 3'd0);
        add_entry(M_NEXT, HOLD, 4'd9, 3'd4, 3'd0);
        add_entry(M_OKAY, HOLD, 4'd9, 3'd4, 3'd4);
        // Cancel keeps settings
        add_entry(M_CANCEL, HOLD, 4'd0, 3'd4, 3'd4);
        // Period item leaves the divider alone
        add_entry(M_OKAY, HOLD, 4'd0, 3'd0, 3'd4);
        add_entry(M_NEXT, HOLD, 4'd1, 3'd0, 3'd4);
        add_entry(M_OKAY, HOLD, 4'd1, 3'd1, 3'd4);
        // Prev beats next
        add_entry(M_PREV | M_NEXT, HOLD, 4'd0, 3'd1, 3'd4);
        // Next beats okay, okay on item 0 would give period 0
        add_entry(M_NEXT | M_OKAY, HOLD, 4'd1, 3'd1, 3'd4);
        add_entry(M_PREV, HOLD, 4'd0, 3'd1, 3'd4);
        add_entry(M_PREV, HOLD, 4'd10, 3'd1, 3'd4);
        // Restore item
        add_entry(M_OKAY, HOLD, 4'd10, 3'd0, 3'd0);
        add_entry(M_CANCEL, HOLD, 4'd0, 3'd0, 3'd0);
        // Long hold, still one step
        add_entry(M_NEXT, LONG_HOLD, 4'd1, 3'd0, 3'd0);
        // Leave both settings nonzero for later phases
        add_entry(M_OKAY, HOLD, 4'd1, 3'd1, 3'd0);
        add_entry(M_PREV, HOLD, 4'd0, 3'd1, 3'd0);
        add_entry(M_PREV, HOLD, 4'd10, 3'd1, 3'd0);
        add_entry(M_PREV, HOLD, 4'd9, 3'd1, 3'd0);
        add_entry(M_OKAY, HOLD, 4'd9, 3'd1, 3'd4);
        table_ready = 1'b1;
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int len;
        int gap;
        logic [3:0] mask;

        rst_n       = 1'b0;
        en          = 1'b1;
        button      = '0;
        errors      = 0;
        checks      = 0;
        seed        = 70;
        table_ready = 1'b0;
        load_table();

        // Reset for two cycles
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_outputs(4'd0, 3'd0, 3'd0, "after reset");

        // Table of presses
        for (int i = 0; i < tbl_mask.size(); i++) begin
            press_buttons(tbl_mask[i], tbl_hold[i]);
            check_outputs(tbl_cursor[i], tbl_period[i], tbl_gain[i],
                          $sformatf("entry %0d", i));
        end

        // Short glitches never reach the menu
        for (int i = 0; i < NUM_GLITCH; i++) begin
            len  = 1 + ({$random(seed)} % (`DEBOUNCE_CYCLES - 2));
            gap  = 1 + ({$random(seed)} % 8);
            mask = 4'(1 + ({$random(seed)} % 15));
            @(posedge clk);
            #1 button = mask;
            repeat (len) @(posedge clk);
            #1 button = '0;
            repeat (gap) @(posedge clk);
        end
        repeat (IDLE) @(posedge clk);
        #1;
        check_outputs(4'd9, 3'd1, 3'd4, "after glitches");

        // Enable low clears everything
        @(posedge clk);
        #1 en = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        check_outputs(4'd0, 3'd0, 3'd0, "en low");
        // Presses while disabled are ignored
        press_buttons(M_NEXT, HOLD);
        check_outputs(4'd0, 3'd0, 3'd0, "next with en low");
        press_buttons(M_PREV, HOLD);
        check_outputs(4'd0, 3'd0, 3'd0, "prev with en low");

        // Back on, next steps from 0
        @(posedge clk);
        #1 en = 1'b1;
        repeat (4) @(posedge clk);
        press_buttons(M_NEXT, HOLD);
        check_outputs(4'd1, 3'd0, 3'd0, "next after en");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    ////////////////////
    // Watchdog
    ////////////////////

    initial begin
        int limit;

        wait (table_ready);
        limit = 0;
        // Table presses
        for (int i = 0; i < tbl_hold.size(); i++) begin
            limit += tbl_hold[i] + IDLE + 10;
        end
        // Glitch run, enable phase and reset
        limit += NUM_GLITCH * (`DEBOUNCE_CYCLES + 10) + IDLE;
        limit += 4 * (HOLD + IDLE + 10);
        limit += 200;
        repeat (limit) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles (%0d ns)",
                 limit, limit * CLK_PERIOD);
        $display("TB FAILED");
        $finish;
    end

endmodule
